//--- Bender.yml
package:
  name: apb_cpu

export_include_dirs:
  - logic

sources:
  - logic/cpu_pkg.sv
  - logic/control_unit.sv
  - logic/alu.sv
  - logic/register_file.sv
  - logic/word_memory.sv
  - logic/cpu_core.sv
  - logic/apb_host_port.sv
  - logic/cpu_top.sv
  - target: test
    files:
      - bench/cpu_top_tb.sv

//--- bench/cpu_top_tb.sv
`default_nettype none

`include "cpu_macros.svh"

module cpu_top_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import cpu_pkg::*;

	localparam int LONG_COUNT = 300;  // Iterations of the busy loop
	localparam int EXEC_CYCLES = 81 + (13 + 10 * 3) + 4 + (7 + LONG_COUNT * 3) + 3 + 5;
	localparam int APB_CYCLES = 4 * (81 + 13 + 4 + 7 + 3 + 5 + 40);  // Loads, starts, reads
	localparam int TIMEOUT_CYCLES = 2 * (8 + EXEC_CYCLES + APB_CYCLES);

	logic     clk = 1'b0;
	logic     reset;
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	out_t     out;
	word_t    rng_state = 32'hb366_ccc8;
	int       cycle_count = 0;
	word_t    prog[$];      // Program image with one word per instruction
	word_t    exp_out[$];
	word_t    out_seen[$];

	cpu_top i_cpu_top (
		.i_clk   (clk),
		.i_reset (reset),
		.i_apb   (apb),
		.o_apb   (apb_rsp),
		.o_out   (out)
	);

	always #4 clk = ~clk;

	always @(negedge clk) begin
		if (!reset && out.valid)
			out_seen.push_back(out.data);  // One entry per valid cycle
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the core never reported halted", cycle_count);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	function automatic word_t next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic word_t sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Reference ALU model with signed division
	function automatic word_t ref_alu(func_t fn, word_t a, word_t b);
		case (fn)
			FN_ADD:  return a + b;
			FN_SUB:  return a - b;
			FN_MUL:  return a * b;
			FN_DIV:  return (b == 0) ? 32'hffff_ffff : word_t'($signed(a) / $signed(b));
			FN_MOD:  return (b == 0) ? a : word_t'($signed(a) % $signed(b));
			FN_AND:  return a & b;
			FN_OR:   return a | b;
			FN_XOR:  return a ^ b;
			FN_LAND: return word_t'((a != 0) && (b != 0));
			FN_LOR:  return word_t'((a != 0) || (b != 0));
			FN_SLL:  return a << b[4:0];
			FN_SRL:  return a >> b[4:0];
			FN_EQ:   return word_t'(a == b);
			FN_NE:   return word_t'(a != b);
			FN_LT:   return word_t'($signed(a) < $signed(b));
			FN_LE:   return word_t'($signed(a) <= $signed(b));
			FN_GT:   return word_t'($signed(a) > $signed(b));
			FN_GE:   return word_t'($signed(a) >= $signed(b));
			default: return '0;
		endcase
	endfunction

	function automatic word_t enc_reg(opcode_t op, func_t fn, logic [4:0] rd, logic [4:0] rs,
			logic [4:0] rt);
		return {op, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_imm(opcode_t op, logic [4:0] rt, logic [4:0] rs,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t enc_jump(opcode_t op, logic [25:0] target);
		return {op, target};
	endfunction

	function automatic apb_rsp_t expect_rsp(logic err, word_t data);
		apb_rsp_t r;
		r.pready = 1'b1;
		r.pslverr = err;
		r.prdata = data;
		return r;
	endfunction

	task automatic emit(word_t w);
		prog.push_back(w);
	endtask

	task automatic emit_out(logic [4:0] rs);
		emit(enc_imm(OP_OUT, 5'd0, rs, 16'd0));
	endtask

	// Full 32-bit constant in three instructions where xori undoes the sign extension
	task automatic emit_const(logic [4:0] rd, word_t value);
		emit(enc_imm(OP_LI, rd, 5'd0, value[31:16] ^ {16{value[15]}}));
		emit(enc_imm(OP_SLLI, rd, rd, 16'd16));
		emit(enc_imm(OP_XORI, rd, rd, value[15:0]));
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first failed check");
		end
	endtask

	task automatic check_rsp(string name, apb_rsp_t got, apb_rsp_t exp);
		if (got.pready !== exp.pready || got.pslverr !== exp.pslverr
				|| got.prdata !== exp.prdata) begin
			$display("FAILED %s: pready %h pslverr %h prdata %h", name, got.pready,
				got.pslverr, got.prdata);
			$display("expected pready %h pslverr %h prdata %h", exp.pready, exp.pslverr,
				exp.prdata);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first failed check");
		end
	endtask

	task automatic check_status(string name, logic [2:0] got, logic [2:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first failed check");
		end
	endtask

	task automatic check_cond(bit ok, string what);
		if (!ok) begin
			$display("Error: %s", what);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at first failed check");
		end
	endtask

	task automatic apb_transfer(logic write, logic [11:0] addr, word_t data,
			output apb_rsp_t rsp);
		@(posedge clk);
		apb <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
		@(posedge clk);
		apb.penable <= 1'b1;
		@(negedge clk);
		rsp = apb_rsp;  // Middle of the access phase
		@(posedge clk);
		apb <= '0;
	endtask

	task automatic read_status(output logic [2:0] status);
		apb_rsp_t rsp;
		apb_transfer(1'b0, `CPU_REG_STATUS, '0, rsp);
		check_cond(rsp.pslverr === 1'b0, "status read returned an error");
		status = rsp.prdata[2:0];
	endtask

	task automatic load_program();
		apb_rsp_t rsp;
		foreach (prog[i]) begin
			apb_transfer(1'b1, 12'(i * 4), prog[i], rsp);
			check_rsp("imem write", rsp, expect_rsp(1'b0, '0));
		end
		out_seen.delete();
	endtask

	task automatic start_core();
		apb_rsp_t rsp;
		apb_transfer(1'b1, `CPU_REG_CTRL, 32'd1, rsp);
		check_rsp("start write", rsp, expect_rsp(1'b0, '0));
	endtask

	task automatic wait_halted(output logic [2:0] status);
		status = 3'b000;
		while (!status[1])
			read_status(status);
	endtask

	task automatic run_program(output logic [2:0] status);
		load_program();
		start_core();
		wait_halted(status);
	endtask

	task automatic check_outputs();
		check_cond(out_seen.size() == exp_out.size(), $sformatf(
			"core sent %0d out values where %0d were expected", out_seen.size(), exp_out.size()));
		foreach (exp_out[i])
			check_word($sformatf("o_out.data[%0d]", i), out_seen[i], exp_out[i]);
	endtask

	task automatic test_reset();
		apb_rsp_t   rsp;
		logic [2:0] status;
		read_status(status);
		check_status("status after reset", status, 3'b000);
		check_cond(out_seen.size() == 0 && out.valid === 1'b0, "out valid rose after reset");
		apb_transfer(1'b0, 12'h40c, '0, rsp);
		check_rsp("unmapped read", rsp, expect_rsp(1'b1, '0));
	endtask

	task automatic test_alu();
		opcode_t    imm_ops [12] = '{OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI,
			OP_ORI, OP_XORI, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI};
		func_t      imm_fns [12] = '{FN_ADD, FN_SUB, FN_MUL, FN_DIV, FN_MOD, FN_AND,
			FN_OR, FN_XOR, FN_LAND, FN_LOR, FN_SLL, FN_SRL};
		word_t      a;
		word_t      b;
		word_t      r;
		logic [2:0] status;
		prog.delete();
		exp_out.delete();
		a = next_random();
		b = next_random();
		emit_const(5'd1, a);
		emit_const(5'd2, b);
		for (int f = 0; f <= 17; f++) begin
			emit(enc_reg(OP_RTYPE, func_t'(f), 5'd3, 5'd1, 5'd2));
			emit_out(5'd3);
			exp_out.push_back(ref_alu(func_t'(f), a, b));
		end
		emit(enc_reg(OP_RTYPE, FN_EQ, 5'd3, 5'd1, 5'd1));  // Compare that holds
		emit_out(5'd3);
		exp_out.push_back(32'd1);
		foreach (imm_ops[i]) begin
			r = next_random();
			emit(enc_imm(imm_ops[i], 5'd3, 5'd1, r[15:0]));
			emit_out(5'd3);
			exp_out.push_back(ref_alu(imm_fns[i], a, sext16(r[15:0])));
		end
		emit(enc_imm(OP_NOT, 5'd3, 5'd1, 16'd0));
		emit_out(5'd3);
		exp_out.push_back(~a);
		emit(enc_reg(OP_MOV, FN_ADD, 5'd3, 5'd0, 5'd2));
		emit_out(5'd3);
		exp_out.push_back(b);
		emit(enc_reg(OP_RTYPE, FN_DIV, 5'd3, 5'd1, 5'd0));  // Divide by r0
		emit_out(5'd3);
		emit(enc_reg(OP_RTYPE, FN_MOD, 5'd3, 5'd1, 5'd0));
		emit_out(5'd3);
		emit(enc_imm(OP_DIVI, 5'd3, 5'd1, 16'd0));
		emit_out(5'd3);
		emit(enc_imm(OP_MODI, 5'd3, 5'd1, 16'd0));
		emit_out(5'd3);
		exp_out.push_back(32'hffff_ffff);
		exp_out.push_back(a);
		exp_out.push_back(32'hffff_ffff);
		exp_out.push_back(a);
		emit(enc_jump(OP_HALT, 26'd0));
		run_program(status);
		check_status("status after ALU program", status, 3'b010);
		check_outputs();
	endtask

	task automatic test_flow();
		word_t      v;
		int         n;
		logic [2:0] status;
		prog.delete();
		exp_out.delete();
		v = next_random();
		n = int'(next_random() % 10) + 1;
		emit(enc_imm(OP_LI, 5'd1, 5'd0, v[15:0]));        // 0
		emit(enc_imm(OP_SW, 5'd1, 5'd0, 16'd5));          // 1 mem[5] = r1
		emit(enc_imm(OP_LW, 5'd2, 5'd0, 16'd5));          // 2
		emit_out(5'd2);                                   // 3
		emit(enc_jump(OP_JAL, 26'd12));                   // 4
		emit_out(5'd31);                                  // 5 Link value
		emit(enc_imm(OP_LI, 5'd4, 5'd0, 16'(n)));         // 6
		emit_out(5'd4);                                   // 7 Loop head
		emit(enc_imm(OP_SUBI, 5'd4, 5'd4, 16'd1));        // 8
		emit(enc_imm(OP_JF, 5'd0, 5'd4, 16'd11));         // 9 Exit at zero
		emit(enc_jump(OP_J, 26'd7));                      // 10
		emit(enc_jump(OP_HALT, 26'd0));                   // 11
		emit(enc_reg(OP_RTYPE, FN_JR, 5'd0, 5'd31, 5'd0)); // 12 Return
		exp_out.push_back(sext16(v[15:0]));
		exp_out.push_back(32'd5);
		for (int i = n; i >= 1; i--)
			exp_out.push_back(word_t'(i));
		run_program(status);
		check_status("status after flow program", status, 3'b010);
		check_outputs();
	endtask

	task automatic test_halt();
		apb_rsp_t   rsp;
		word_t      v;
		logic [2:0] status;
		prog.delete();
		exp_out.delete();
		v = next_random();
		emit(enc_imm(OP_LI, 5'd1, 5'd0, v[15:0]));
		emit_out(5'd1);
		emit(enc_jump(OP_HALT, 26'd0));
		emit_out(5'd1);  // Never reached
		exp_out.push_back(sext16(v[15:0]));
		run_program(status);
		check_status("status after halt", status, 3'b010);
		check_outputs();
		apb_transfer(1'b0, `CPU_REG_OUT, '0, rsp);
		check_rsp("out register after halt", rsp, expect_rsp(1'b0, sext16(v[15:0])));
	endtask

	task automatic test_busy();
		apb_rsp_t   rsp;
		word_t      v;
		logic [2:0] status;
		prog.delete();
		exp_out.delete();
		emit(enc_imm(OP_LI, 5'd5, 5'd0, 16'(LONG_COUNT)));
		emit(enc_imm(OP_LI, 5'd6, 5'd0, 16'h1234));
		emit(enc_imm(OP_SUBI, 5'd5, 5'd5, 16'd1));  // 2 Loop head
		emit(enc_imm(OP_JF, 5'd0, 5'd5, 16'd5));
		emit(enc_jump(OP_J, 26'd2));
		emit_out(5'd6);                              // 5 Target of the rejected write
		emit(enc_jump(OP_HALT, 26'd0));
		exp_out.push_back(32'h1234);
		load_program();
		start_core();
		apb_transfer(1'b1, 12'h014, enc_jump(OP_HALT, 26'd0), rsp);
		check_rsp("imem write while running", rsp, expect_rsp(1'b1, '0));
		apb_transfer(1'b1, `CPU_REG_CTRL, 32'd1, rsp);
		check_rsp("start while running", rsp, expect_rsp(1'b1, '0));
		read_status(status);
		check_status("status while running", status, 3'b001);
		wait_halted(status);
		check_status("status after busy loop", status, 3'b010);
		check_outputs();
		prog.delete();
		exp_out.delete();
		v = next_random();
		emit(enc_imm(OP_LI, 5'd1, 5'd0, v[15:0]));
		emit_out(5'd1);
		emit(enc_jump(OP_HALT, 26'd0));
		exp_out.push_back(sext16(v[15:0]));
		run_program(status);
		check_status("status after reload", status, 3'b010);
		check_outputs();
	endtask

	task automatic test_illegal();
		word_t      v;
		logic [2:0] status;
		prog.delete();
		exp_out.delete();
		v = next_random();
		emit(enc_imm(OP_LI, 5'd1, 5'd0, v[15:0]));
		emit_out(5'd1);
		emit({6'd30, 26'd0});  // MMU opcode
		emit_out(5'd1);
		emit(enc_jump(OP_HALT, 26'd0));
		exp_out.push_back(sext16(v[15:0]));
		run_program(status);
		check_status("status after illegal opcode", status, 3'b110);
		check_outputs();
	endtask

	initial begin
		reset = 1'b1;
		apb = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		test_reset();
		test_alu();
		test_flow();
		test_halt();
		test_busy();
		test_illegal();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_t i_op,
	input  cpu_pkg::word_t   i_a,
	input  cpu_pkg::word_t   i_b,
	output cpu_pkg::word_t   o_result
);
	import cpu_pkg::*;

	logic signed [$bits(word_t)-1:0] a_s;
	logic signed [$bits(word_t)-1:0] b_s;
	logic                            b_zero;

	assign a_s = i_a;
	assign b_s = i_b;
	assign b_zero = (i_b == '0);

	always_comb begin
		case (i_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_MUL:    o_result = i_a * i_b;  // Low half of the product
			ALU_DIV:    o_result = b_zero ? '1 : word_t'(a_s / b_s);
			ALU_MOD:    o_result = b_zero ? i_a : word_t'(a_s % b_s);
			ALU_AND:    o_result = i_a & i_b;
			ALU_OR:     o_result = i_a | i_b;
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_LAND:   o_result = word_t'((i_a != '0) && (i_b != '0));
			ALU_LOR:    o_result = word_t'((i_a != '0) || (i_b != '0));
			ALU_NOT:    o_result = ~i_a;
			ALU_SLL:    o_result = i_a << i_b[4:0];
			ALU_SRL:    o_result = i_a >> i_b[4:0];
			ALU_EQ:     o_result = word_t'(i_a == i_b);
			ALU_NE:     o_result = word_t'(i_a != i_b);
			ALU_LT:     o_result = word_t'(a_s < b_s);  // Signed compares
			ALU_LE:     o_result = word_t'(a_s <= b_s);
			ALU_GT:     o_result = word_t'(a_s > b_s);
			ALU_GE:     o_result = word_t'(a_s >= b_s);
			ALU_PASS_B: o_result = i_b;
			default:    o_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/apb_host_port.sv
`default_nettype none

`include "cpu_macros.svh"

module apb_host_port (
	input  logic               i_clk,
	input  logic               i_reset,
	input  cpu_pkg::apb_req_t  i_apb,
	output cpu_pkg::apb_rsp_t  o_apb,
	output cpu_pkg::imem_wr_t  o_imem_wr,
	output logic               o_start,
	input  logic               i_running,
	input  logic               i_halted,
	input  logic               i_fault,
	input  cpu_pkg::out_t      i_out
);
	import cpu_pkg::*;

	logic  access;
	logic  wr;
	logic  is_imem;
	logic  is_ctrl;
	logic  is_status;
	logic  is_out;
	logic  err;
	logic  start_q;
	word_t last_out;

	assign access = i_apb.psel & i_apb.penable;
	assign wr = access & i_apb.pwrite;

	// Instruction words at 0x000 to 0x3FC, write only
	assign is_imem = (i_apb.paddr[11:10] == 2'b00) && (i_apb.paddr[1:0] == 2'b00);
	assign is_ctrl = (i_apb.paddr == `CPU_REG_CTRL);
	assign is_status = (i_apb.paddr == `CPU_REG_STATUS);
	assign is_out = (i_apb.paddr == `CPU_REG_OUT);

	always_comb begin
		if (i_apb.pwrite)
			err = !(is_imem || is_ctrl)  // Status and out are read only
				|| (is_imem && i_running)
				|| (is_ctrl && i_apb.pwdata[0] && i_running);
		else
			err = !(is_ctrl || is_status || is_out);
	end

	always_comb begin
		o_apb.pready = access;  // No wait states
		o_apb.pslverr = access & err;
		if (is_status)
			o_apb.prdata = word_t'({i_fault, i_halted, i_running});
		else if (is_out)
			o_apb.prdata = last_out;
		else
			o_apb.prdata = '0;
	end

	assign o_imem_wr.en = wr & is_imem & ~i_running;
	assign o_imem_wr.index = i_apb.paddr[9:2];
	assign o_imem_wr.instr = instr_t'(i_apb.pwdata);

	always_ff @(posedge i_clk) begin
		if (i_reset)
			start_q <= 1'b0;
		else
			start_q <= wr & is_ctrl & i_apb.pwdata[0] & ~i_running;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			last_out <= '0;
		else if (i_out.valid)
			last_out <= i_out.data;
	end

	assign o_start = start_q;

	a_apb_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_apb.psel && !i_apb.penable) |=> (i_apb.psel && i_apb.penable
			&& $stable(i_apb.paddr) && $stable(i_apb.pwrite) && $stable(i_apb.pwdata)))
		else $error("APB request changed between setup and access");

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`default_nettype none

module control_unit (
	input  cpu_pkg::opcode_t i_op,
	input  cpu_pkg::func_t   i_func,
	input  logic             i_is_false,  // Register rs is zero
	output cpu_pkg::ctrl_t   o_ctrl
);
	import cpu_pkg::*;

	alu_op_t func_alu_op;  // Operation picked by the R-type function field
	logic    func_valid;
	alu_op_t imm_alu_op;   // Operation picked by an immediate opcode

	always_comb begin
		func_alu_op = ALU_ADD;
		func_valid = 1'b1;
		case (i_func)
			FN_ADD:  func_alu_op = ALU_ADD;
			FN_SUB:  func_alu_op = ALU_SUB;
			FN_MUL:  func_alu_op = ALU_MUL;
			FN_DIV:  func_alu_op = ALU_DIV;
			FN_MOD:  func_alu_op = ALU_MOD;
			FN_AND:  func_alu_op = ALU_AND;
			FN_OR:   func_alu_op = ALU_OR;
			FN_XOR:  func_alu_op = ALU_XOR;
			FN_LAND: func_alu_op = ALU_LAND;
			FN_LOR:  func_alu_op = ALU_LOR;
			FN_SLL:  func_alu_op = ALU_SLL;
			FN_SRL:  func_alu_op = ALU_SRL;
			FN_EQ:   func_alu_op = ALU_EQ;
			FN_NE:   func_alu_op = ALU_NE;
			FN_LT:   func_alu_op = ALU_LT;
			FN_LE:   func_alu_op = ALU_LE;
			FN_GT:   func_alu_op = ALU_GT;
			FN_GE:   func_alu_op = ALU_GE;
			FN_JR:   func_alu_op = ALU_ADD;  // ALU result unused
			default: func_valid = 1'b0;
		endcase
	end

	always_comb begin
		case (i_op)
			OP_SUBI:  imm_alu_op = ALU_SUB;
			OP_MULI:  imm_alu_op = ALU_MUL;
			OP_DIVI:  imm_alu_op = ALU_DIV;
			OP_MODI:  imm_alu_op = ALU_MOD;
			OP_ANDI:  imm_alu_op = ALU_AND;
			OP_ORI:   imm_alu_op = ALU_OR;
			OP_XORI:  imm_alu_op = ALU_XOR;
			OP_NOT:   imm_alu_op = ALU_NOT;
			OP_LANDI: imm_alu_op = ALU_LAND;
			OP_LORI:  imm_alu_op = ALU_LOR;
			OP_SLLI:  imm_alu_op = ALU_SLL;
			OP_SRLI:  imm_alu_op = ALU_SRL;
			default:  imm_alu_op = ALU_ADD;  // addi, lw and sw address
		endcase
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.pc_src = PC_NEXT;
		o_ctrl.wb_src = WB_ALU;
		o_ctrl.alu_op = ALU_ADD;
		case (i_op)
			OP_RTYPE: begin
				o_ctrl.alu_src_reg = 1'b1;
				o_ctrl.alu_op = func_alu_op;
				if (!func_valid)
					o_ctrl.illegal = 1'b1;
				else if (i_func == FN_JR)
					o_ctrl.pc_src = PC_REGISTER;
				else
					o_ctrl.reg_write = 1'b1;
			end
			OP_ADDI, OP_SUBI, OP_MULI, OP_DIVI, OP_MODI, OP_ANDI, OP_ORI,
			OP_XORI, OP_NOT, OP_LANDI, OP_LORI, OP_SLLI, OP_SRLI: begin
				o_ctrl.rt_dest = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = imm_alu_op;
			end
			OP_MOV: begin  // rd gets rt
				o_ctrl.alu_src_reg = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = ALU_PASS_B;
			end
			OP_LI: begin
				o_ctrl.rt_dest = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.alu_op = ALU_PASS_B;
			end
			OP_LW: begin
				o_ctrl.rt_dest = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_src = WB_MEMORY;
			end
			OP_SW:   o_ctrl.mem_write = 1'b1;
			OP_OUT:  o_ctrl.out_write = 1'b1;
			OP_JF: begin
				if (i_is_false)
					o_ctrl.pc_src = PC_BRANCH;
			end
			OP_J:    o_ctrl.pc_src = PC_JUMP;
			OP_JAL: begin
				o_ctrl.pc_src = PC_JUMP;
				o_ctrl.link = 1'b1;
				o_ctrl.reg_write = 1'b1;
				o_ctrl.wb_src = WB_LINK;
			end
			OP_HALT: o_ctrl.halt = 1'b1;
			default: o_ctrl.illegal = 1'b1;  // MMU, disk, LCD, syscall and others
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cpu_core.sv
`default_nettype none

`include "cpu_macros.svh"

module cpu_core (
	input  logic             i_clk,
	input  logic             i_reset,
	input  logic             i_start,
	input  cpu_pkg::instr_t  i_instr,
	output logic [7:0]       o_pc,
	output logic             o_running,
	output logic             o_halted,
	output logic             o_fault,
	output cpu_pkg::out_t    o_out
);
	import cpu_pkg::*;

	localparam int DMEM_IDX_W = $clog2(`CPU_DMEM_DEPTH);

	logic [7:0]  pc;
	logic [7:0]  pc_plus1;
	logic [7:0]  pc_next;
	logic        running;
	logic        halted;
	logic        fault;
	logic        stop;
	ctrl_t       ctrl;
	word_t       rs_data;
	word_t       rt_data;
	word_t       imm_ext;
	logic [25:0] jump_target;
	word_t       alu_b;
	word_t       alu_result;
	word_t       mem_rd_data;
	word_t       wb_data;
	logic [4:0]  wr_addr;
	logic        rf_wr_en;
	logic        dm_wr_en;
	out_t        out_q;

	assign imm_ext = {{(`CPU_DATA_W-16){i_instr[15]}}, i_instr[15:0]};
	assign jump_target = i_instr[25:0];
	assign pc_plus1 = pc + 8'd1;
	assign stop = ctrl.halt | ctrl.illegal;

	control_unit u_control_unit (
		.i_op       (i_instr.op),
		.i_func     (i_instr.func),
		.i_is_false (rs_data == '0),
		.o_ctrl     (ctrl)
	);

	assign alu_b = ctrl.alu_src_reg ? rt_data : imm_ext;

	alu u_alu (
		.i_op     (ctrl.alu_op),
		.i_a      (rs_data),
		.i_b      (alu_b),
		.o_result (alu_result)
	);

	// Nothing is written unless a program runs
	assign rf_wr_en = running & ctrl.reg_write;
	assign dm_wr_en = running & ctrl.mem_write;
	assign wr_addr = ctrl.link ? 5'd31 : (ctrl.rt_dest ? i_instr.rt : i_instr.rd);

	always_comb begin
		case (ctrl.wb_src)
			WB_MEMORY: wb_data = mem_rd_data;
			WB_LINK:   wb_data = word_t'(pc_plus1);
			default:   wb_data = alu_result;
		endcase
	end

	register_file u_register_file (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_rs_addr (i_instr.rs),
		.i_rt_addr (i_instr.rt),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data),
		.i_wr_en   (rf_wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wb_data)
	);

	// Address is rs plus offset and store data comes from rt
	word_memory #(
		.DEPTH     (`CPU_DMEM_DEPTH),
		.payload_t (word_t)
	) u_dmem (
		.i_clk      (i_clk),
		.i_wr_en    (dm_wr_en),
		.i_wr_index (alu_result[DMEM_IDX_W-1:0]),
		.i_wr_data  (rt_data),
		.i_rd_index (alu_result[DMEM_IDX_W-1:0]),
		.o_rd_data  (mem_rd_data)
	);

	always_comb begin
		case (ctrl.pc_src)
			PC_BRANCH:   pc_next = imm_ext[7:0];      // Absolute word index
			PC_REGISTER: pc_next = rs_data[7:0];
			PC_JUMP:     pc_next = jump_target[7:0];
			default:     pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc <= '0;
			running <= 1'b0;
			halted <= 1'b0;
			fault <= 1'b0;
		end else if (i_start) begin
			pc <= '0;
			running <= 1'b1;
			halted <= 1'b0;
			fault <= 1'b0;
		end else if (running) begin
			if (stop) begin  // PC stays on the stopping instruction
				running <= 1'b0;
				halted <= 1'b1;
				fault <= ctrl.illegal;
			end else begin
				pc <= pc_next;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset)
			out_q.valid <= 1'b0;
		else
			out_q.valid <= running & ctrl.out_write;  // One pulse per out
	end

	always_ff @(posedge i_clk) begin
		if (running && ctrl.out_write)
			out_q.data <= rs_data;
	end

	assign o_pc = pc;
	assign o_running = running;
	assign o_halted = halted;
	assign o_fault = fault;
	assign o_out = out_q;

	a_run_state_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
		!(running && halted))
		else $error("core running and halted at once");

	// A halt or illegal instruction leaves all state untouched
	a_no_write_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		(!running || stop) |-> !(rf_wr_en || dm_wr_en))
		else $error("state write while core idle or stopping");

endmodule

`default_nettype wire

//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path width
`define CPU_DATA_W 32

// Memory sizes in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// APB byte offsets of the control registers
`define CPU_REG_CTRL   12'h400
`define CPU_REG_STATUS 12'h404
`define CPU_REG_OUT    12'h408

`endif

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,  OP_ADDI = 6'd1,  OP_SUBI = 6'd2,  OP_MULI = 6'd3,
		OP_DIVI  = 6'd4,  OP_MODI = 6'd5,  OP_ANDI = 6'd6,  OP_ORI  = 6'd7,
		OP_XORI  = 6'd8,  OP_NOT  = 6'd9,  OP_LANDI = 6'd10, OP_LORI = 6'd11,
		OP_SLLI  = 6'd12, OP_SRLI = 6'd13, OP_MOV  = 6'd14, OP_LW   = 6'd15,
		OP_LI    = 6'd16, OP_SW   = 6'd18, OP_OUT  = 6'd20, OP_JF   = 6'd21,
		OP_J     = 6'd22, OP_JAL  = 6'd23, OP_HALT = 6'd24
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,  FN_SUB = 6'd1,  FN_MUL = 6'd2,  FN_DIV  = 6'd3,
		FN_MOD = 6'd4,  FN_AND = 6'd5,  FN_OR  = 6'd6,  FN_XOR  = 6'd7,
		FN_LAND = 6'd8, FN_LOR = 6'd9,  FN_SLL = 6'd10, FN_SRL  = 6'd11,
		FN_EQ  = 6'd12, FN_NE  = 6'd13, FN_LT  = 6'd14, FN_LE   = 6'd15,
		FN_GT  = 6'd16, FN_GE  = 6'd17, FN_JR  = 6'd18
	} func_t;

	// Immediate overlays [15:0], jump target overlays [25:0]
	typedef struct packed {
		opcode_t    op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;  // Not used, shifts take rt or the immediate
		func_t      func;
	} instr_t;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_MUL, ALU_DIV, ALU_MOD,
		ALU_AND, ALU_OR, ALU_XOR, ALU_LAND, ALU_LOR, ALU_NOT,
		ALU_SLL, ALU_SRL,
		ALU_EQ, ALU_NE, ALU_LT, ALU_LE, ALU_GT, ALU_GE,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_REGISTER, PC_JUMP} pc_src_t;

	typedef enum logic [1:0] {WB_ALU, WB_MEMORY, WB_LINK} wb_src_t;

	typedef struct packed {
		logic    reg_write;
		logic    mem_write;
		logic    alu_src_reg;  // ALU operand b from rt instead of the immediate
		logic    rt_dest;
		logic    link;         // Destination is r31
		logic    out_write;
		logic    halt;
		logic    illegal;
		pc_src_t pc_src;
		wb_src_t wb_src;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} out_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		word_t       pwdata;
	} apb_req_t;

	typedef struct packed {
		logic  pready;
		logic  pslverr;
		word_t prdata;
	} apb_rsp_t;

	typedef struct packed {
		logic       en;
		logic [7:0] index;
		instr_t     instr;
	} imem_wr_t;

endpackage

`default_nettype wire

//--- logic/cpu_top.sv
`default_nettype none

`include "cpu_macros.svh"

module cpu_top (
	input  logic              i_clk,
	input  logic              i_reset,
	input  cpu_pkg::apb_req_t i_apb,
	output cpu_pkg::apb_rsp_t o_apb,
	output cpu_pkg::out_t     o_out
);
	import cpu_pkg::*;

	imem_wr_t   imem_wr;
	logic       start;
	logic       running;
	logic       halted;
	logic       fault;
	logic [7:0] pc;
	instr_t     instr;

	apb_host_port u_apb_host_port (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_apb     (i_apb),
		.o_apb     (o_apb),
		.o_imem_wr (imem_wr),
		.o_start   (start),
		.i_running (running),
		.i_halted  (halted),
		.i_fault   (fault),
		.i_out     (o_out)
	);

	word_memory #(
		.DEPTH     (`CPU_IMEM_DEPTH),
		.payload_t (instr_t)
	) u_imem (
		.i_clk      (i_clk),
		.i_wr_en    (imem_wr.en),
		.i_wr_index (imem_wr.index),
		.i_wr_data  (imem_wr.instr),
		.i_rd_index (pc),
		.o_rd_data  (instr)
	);

	cpu_core u_cpu_core (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_start   (start),
		.i_instr   (instr),
		.o_pc      (pc),
		.o_running (running),
		.o_halted  (halted),
		.o_fault   (fault),
		.o_out     (o_out)
	);

endmodule

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
	input  logic           i_clk,
	input  logic           i_reset,
	input  logic [4:0]     i_rs_addr,
	input  logic [4:0]     i_rt_addr,
	output cpu_pkg::word_t o_rs_data,
	output cpu_pkg::word_t o_rt_data,
	input  logic           i_wr_en,
	input  logic [4:0]     i_wr_addr,
	input  cpu_pkg::word_t i_wr_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (i_wr_en && (i_wr_addr != 5'd0)) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	assign o_rs_data = (i_rs_addr == 5'd0) ? '0 : regs[i_rs_addr];  // r0 is hardwired
	assign o_rt_data = (i_rt_addr == 5'd0) ? '0 : regs[i_rt_addr];

	a_wr_addr_known: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wr_en |-> !$isunknown(i_wr_addr))
		else $error("register write with unknown address");

endmodule

`default_nettype wire

//--- logic/word_memory.sv
`default_nettype none

module word_memory #(
	parameter int  DEPTH     = 256,
	parameter type payload_t = logic [31:0]
) (
	input  logic                     i_clk,
	input  logic                     i_wr_en,
	input  logic [$clog2(DEPTH)-1:0] i_wr_index,
	input  payload_t                 i_wr_data,
	input  logic [$clog2(DEPTH)-1:0] i_rd_index,
	output payload_t                 o_rd_data
);

	localparam int IDX_W = $clog2(DEPTH);

	payload_t mem [DEPTH];

	logic [IDX_W-1:0] wr_slot;
	logic [IDX_W-1:0] rd_slot;

	// Indices wrap at DEPTH
	assign wr_slot = IDX_W'(i_wr_index % DEPTH);
	assign rd_slot = IDX_W'(i_rd_index % DEPTH);

	always_ff @(posedge i_clk) begin
		if (i_wr_en)
			mem[wr_slot] <= i_wr_data;
	end

	assign o_rd_data = mem[rd_slot];  // Read has no latency

	a_wr_index_known: assert property (@(posedge i_clk)
		i_wr_en |-> !$isunknown(i_wr_index))
		else $error("memory write with unknown index");

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/cpu_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_file.sv
logic/word_memory.sv
logic/cpu_core.sv
logic/apb_host_port.sv
logic/cpu_top.sv
bench/cpu_top_tb.sv
